// File: verilog/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// depth of the data array in 32-bit words
// power of two so the word index wraps
`define MEM_WORDS 64

// byte address width of a request
`define MEM_AW 32

`endif

// File: verilog/mem_pkg.sv
`include "mem_defs.svh"

package mem_pkg;

    // access type with codes 5..7 unused
    typedef enum logic [2:0] {
        MEM_DT_BYTE  = 3'd0,  // signed byte
        MEM_DT_HALF  = 3'd1,  // signed halfword
        MEM_DT_WORD  = 3'd2,  // full word
        MEM_DT_UBYTE = 3'd3,  // unsigned byte
        MEM_DT_UHALF = 3'd4   // unsigned halfword
    } mem_dt_e;

    // error code of one access
    typedef enum logic [1:0] {
        ERR_NONE       = 2'd0,
        ERR_MISALIGNED = 2'd1,  // half on odd addr or word off a boundary
        ERR_BAD_TYPE   = 2'd2   // dt outside the table
    } errno_e;

    // one load/store request of 68 bits
    typedef struct packed {
        logic [`MEM_AW-1:0] addr;  // byte address
        logic [31:0]        wd;    // store data, right-aligned
        logic               we;    // store strobe
        mem_dt_e            dt;    // access type
    } mem_req_t;

    // one stored word seen three ways
    // b[0] and h[0] are the low lanes
    typedef union packed {
        logic [31:0]          w;  // whole word
        logic [3:0][7:0]      b;  // byte lanes
        logic [1:0][15:0]     h;  // halfword lanes
    } mem_word_u;

endpackage

// File: verilog/mem_access.sv
`timescale 1ns/10ps

module mem_access (
    input  logic              rst_n,  // low blocks stores only
    input  mem_pkg::mem_req_t req,
    output logic [3:0]        be,     // lane enables to storage
    output logic              se,     // sign extend narrow loads
    output logic              wr,     // gated store strobe
    output mem_pkg::errno_e   err
);
    logic [3:0] byte_be;   // one-hot lane from addr[1:0]
    logic [3:0] half_be;   // low or high half
    logic       half_mis;  // halfword on odd address
    logic       word_mis;  // word off a word boundary

    // 2-to-4 lane decode for byte accesses
    always_comb begin
        case (req.addr[1:0])
            2'd0:    byte_be = 4'b0001;
            2'd1:    byte_be = 4'b0010;
            2'd2:    byte_be = 4'b0100;
            default: byte_be = 4'b1000;
        endcase
    end

    assign half_be  = req.addr[1] ? 4'b1100 : 4'b0011;  // addr[1] picks the half
    assign half_mis = req.addr[0];
    assign word_mis = |req.addr[1:0];

    // type decode with enables and error
    always_comb begin
        be  = 4'b0000;  // invalid type keeps all lanes off
        se  = 1'b0;
        err = mem_pkg::ERR_NONE;
        case (req.dt)
            mem_pkg::MEM_DT_BYTE: begin
                be = byte_be;
                se = 1'b1;
            end
            mem_pkg::MEM_DT_UBYTE: begin
                be = byte_be;  // zero filled
            end
            mem_pkg::MEM_DT_HALF: begin
                be = half_be;
                se = 1'b1;
                if (half_mis) begin
                    err = mem_pkg::ERR_MISALIGNED;
                end
            end
            mem_pkg::MEM_DT_UHALF: begin
                be = half_be;
                if (half_mis) begin
                    err = mem_pkg::ERR_MISALIGNED;
                end
            end
            mem_pkg::MEM_DT_WORD: begin
                be = 4'b1111;  // no extension on a full word
                if (word_mis) begin
                    err = mem_pkg::ERR_MISALIGNED;
                end
            end
            default: begin
                err = mem_pkg::ERR_BAD_TYPE;  // codes 5..7
            end
        endcase
    end

    // store only on a clean access out of reset
    assign wr = req.we && (err == mem_pkg::ERR_NONE) && rst_n;

endmodule

// File: verilog/mem_be.sv
`timescale 1ns/10ps

`include "mem_defs.svh"

module mem_be #(
    parameter int depth = `MEM_WORDS  // depth in words as a power of two
) (
    input  logic        clk,
    input  logic [31:0] addr,  // byte address with lanes picked upstream
    input  logic [31:0] wd,    // right-aligned store data
    input  logic [3:0]  be,    // lane enables
    input  logic        se,    // sign extend on read
    input  logic        wr,    // store strobe gated upstream
    output logic [31:0] rd
);
    localparam int iw = $clog2(depth);  // word index width

    mem_pkg::mem_word_u mem [depth];  // the data array

    logic [iw-1:0]      idx;       // word index wrapping at depth
    mem_pkg::mem_word_u word;      // addressed word
    logic               is_byte;   // single lane enabled
    logic               is_half;   // aligned half enabled
    logic               is_word;   // all four lanes
    logic [1:0]         lane;      // byte lane when is_byte
    logic [7:0]         byte_sel;
    logic [15:0]        half_sel;

    assign idx = addr[iw+1:2];  // modulo depth

    // lane writes through the byte and half views
    always_ff @(posedge clk) begin
        if (wr) begin
            case (be)
                4'b0001: mem[idx].b[0] <= wd[7:0];
                4'b0010: mem[idx].b[1] <= wd[7:0];
                4'b0100: mem[idx].b[2] <= wd[7:0];
                4'b1000: mem[idx].b[3] <= wd[7:0];
                4'b0011: mem[idx].h[0] <= wd[15:0];  // low half
                4'b1100: mem[idx].h[1] <= wd[15:0];  // high half
                4'b1111: mem[idx].w    <= wd;
                default: ;  // other patterns leave the word alone
            endcase
        end
    end

    // combinational read of the addressed word
    assign word = mem[idx];

    // classify the enable pattern
    always_comb begin
        is_byte = 1'b0;
        is_half = 1'b0;
        is_word = 1'b0;
        lane    = 2'd0;
        case (be)
            4'b0001: begin
                is_byte = 1'b1;
            end
            4'b0010: begin
                is_byte = 1'b1;
                lane    = 2'd1;
            end
            4'b0100: begin
                is_byte = 1'b1;
                lane    = 2'd2;
            end
            4'b1000: begin
                is_byte = 1'b1;
                lane    = 2'd3;
            end
            4'b0011, 4'b1100: begin
                is_half = 1'b1;  // be[2] tells which half
            end
            4'b1111: begin
                is_word = 1'b1;
            end
            default: ;  // nothing selected so rd is zero
        endcase
    end

    assign byte_sel = word.b[lane];
    assign half_sel = word.h[be[2]];

    // right-align and extend with the selected msb when se
    always_comb begin
        if (is_word) begin
            rd = word.w;
        end else if (is_half) begin
            rd = {{16{se & half_sel[15]}}, half_sel};
        end else if (is_byte) begin
            rd = {{24{se & byte_sel[7]}}, byte_sel};
        end else begin
            rd = '0;
        end
    end

endmodule

// File: verilog/data_mem.sv
`timescale 1ns/10ps

`include "mem_defs.svh"

module data_mem (
    input  logic              clk,
    input  logic              rst_n,  // synchronous active low reset blocks stores
    input  mem_pkg::mem_req_t req,    // one request per cycle
    output logic [31:0]       rd,     // load data, same cycle
    output mem_pkg::errno_e   err     // alignment / type error
);
    logic [3:0] be;  // lane enables
    logic       se;  // sign extend
    logic       wr;  // store strobe after error and reset gating

    // access control turns type and low address bits into lanes
    mem_access i_mem_access (
        .rst_n (rst_n),
        .req   (req),
        .be    (be),
        .se    (se),
        .wr    (wr),
        .err   (err)
    );

    // storage array with byte lanes
    mem_be #(
        .depth (`MEM_WORDS)
    ) i_mem_be (
        .clk  (clk),
        .addr (req.addr),
        .wd   (req.wd),
        .be   (be),
        .se   (se),
        .wr   (wr),
        .rd   (rd)
    );

endmodule

// File: test/data_mem_checker.sv
`timescale 1ns/10ps

module data_mem_checker (
    input logic              clk,
    input logic              rst_n,
    input mem_pkg::mem_req_t req,
    input logic [31:0]       rd,
    input mem_pkg::errno_e   err
);
    int   fail_count = 0;  // failed assertions so far
    logic half_type;       // signed or unsigned halfword
    logic misaligned;      // alignment rule from type and low address bits

    assign half_type  = (req.dt == mem_pkg::MEM_DT_HALF) || (req.dt == mem_pkg::MEM_DT_UHALF);
    assign misaligned = (half_type && req.addr[0])
                     || ((req.dt == mem_pkg::MEM_DT_WORD) && (req.addr[1:0] != 2'b00));

    // misaligned error exactly when the rule says so
    err_align_a: assert property (@(posedge clk) (err == mem_pkg::ERR_MISALIGNED) == misaligned)
        else begin
            $error("misaligned error does not follow the alignment rule");
            fail_count++;
        end

    // unsigned loads are zero filled above their width
    ubyte_zero_a: assert property (@(posedge clk)
        (req.dt == mem_pkg::MEM_DT_UBYTE) |-> (rd[31:8] == 24'h0))
        else begin
            $error("unsigned byte load not zero filled");
            fail_count++;
        end
    uhalf_zero_a: assert property (@(posedge clk)
        (req.dt == mem_pkg::MEM_DT_UHALF) |-> (rd[31:16] == 16'h0))
        else begin
            $error("unsigned halfword load not zero filled");
            fail_count++;
        end

    // signed loads copy the top bit of the selected data
    byte_sext_a: assert property (@(posedge clk)
        (req.dt == mem_pkg::MEM_DT_BYTE) |-> (rd[31:8] == {24{rd[7]}}))
        else begin
            $error("signed byte load not sign extended");
            fail_count++;
        end
    half_sext_a: assert property (@(posedge clk)
        (req.dt == mem_pkg::MEM_DT_HALF) |-> (rd[31:16] == {16{rd[15]}}))
        else begin
            $error("signed halfword load not sign extended");
            fail_count++;
        end

    // a store held through a reset edge leaves the loaded data as it was
    no_store_in_reset_a: assert property (@(posedge clk)
        ($past(!rst_n && req.we) && $stable(req)) |-> $stable(rd))
        else begin
            $error("store changed the memory while in reset");
            fail_count++;
        end

endmodule

bind data_mem data_mem_checker i_data_mem_checker (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .rd    (rd),
    .err   (err)
);

// File: test/data_mem_tb.sv
`timescale 1ns/10ps

`include "mem_defs.svh"

module data_mem_tb;

    localparam int iw = $clog2(`MEM_WORDS);  // word index width

    logic              clk;
    logic              rst_n;
    mem_pkg::mem_req_t req;
    logic [31:0]       rd;
    mem_pkg::errno_e   err;

    mem_pkg::mem_word_u shadow [`MEM_WORDS];  // reference copy of the array

    logic [31:0] lcg_state;
    int          test_num;
    int          test_checks;   // per test
    int          test_fails;
    int          total_checks;
    int          total_fails;

    data_mem i_data_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .rd    (rd),
        .err   (err)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // cycle-bounded watchdog
    initial begin : watchdog
        int n;
        for (n = 0; n < 3000; n++) begin
            @(posedge clk);
        end
        $display("timeout: the run did not finish within 3000 cycles");
        $display("Checks failed");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // expected error from type and low address bits
    function automatic mem_pkg::errno_e model_err(input logic [31:0] addr, input logic [2:0] dt);
        if (dt > 3'd4) begin
            return mem_pkg::ERR_BAD_TYPE;
        end
        if ((dt == 3'd1 || dt == 3'd4) && addr[0]) begin
            return mem_pkg::ERR_MISALIGNED;  // halfword on odd byte
        end
        if (dt == 3'd2 && addr[1:0] != 2'b00) begin
            return mem_pkg::ERR_MISALIGNED;
        end
        return mem_pkg::ERR_NONE;
    endfunction

    // expected load data with lanes chosen by type even when misaligned
    function automatic logic [31:0] model_rd(input logic [31:0] addr, input logic [2:0] dt);
        mem_pkg::mem_word_u w;
        logic [7:0]         b;
        logic [15:0]        h;
        w = shadow[addr[iw+1:2]];
        b = w.b[addr[1:0]];
        h = w.h[addr[1]];
        case (dt)
            3'd0:    return {{24{b[7]}}, b};   // signed byte
            3'd1:    return {{16{h[15]}}, h};  // signed half
            3'd2:    return w.w;
            3'd3:    return {24'h0, b};
            3'd4:    return {16'h0, h};
            default: return 32'h0;             // no lanes on a bad type
        endcase
    endfunction

    // lane merge of a store into the shadow copy
    function automatic void model_store(input logic [31:0] addr, input logic [31:0] wd,
                                        input logic [2:0] dt);
        logic [iw-1:0] idx;
        idx = addr[iw+1:2];
        case (dt)
            3'd0, 3'd3: shadow[idx].b[addr[1:0]] = wd[7:0];
            3'd1, 3'd4: shadow[idx].h[addr[1]]   = wd[15:0];
            3'd2:       shadow[idx].w            = wd;
            default: ;
        endcase
    endfunction

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        test_checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
            test_fails++;
        end
    endtask

    // one request per cycle checked mid cycle before the model takes the store
    task automatic do_req(input logic [31:0] addr, input logic [31:0] wd, input logic we,
                          input logic [2:0] dt);
        mem_pkg::errno_e exp_err;
        logic [31:0]     exp_rd;
        @(posedge clk);
        #2;
        req.addr = addr;
        req.wd   = wd;
        req.we   = we;
        req.dt   = mem_pkg::mem_dt_e'(dt);
        #10;  // combinational outputs long settled
        exp_err = model_err(addr, dt);
        exp_rd  = model_rd(addr, dt);
        check_eq($sformatf("err addr %h dt %0d", addr, dt), 32'(err), 32'(exp_err));
        check_eq($sformatf("rd addr %h dt %0d", addr, dt), rd, exp_rd);
        if (we && exp_err == mem_pkg::ERR_NONE && rst_n) begin
            model_store(addr, wd, dt);
        end
    endtask

    task automatic set_reset(input logic level);
        @(posedge clk);
        #2;
        rst_n  = level;
        req.we = 1'b0;  // idle while reset moves
    endtask

    task automatic end_test(input string name);
        test_num++;
        $display("test %0d %s: %0d checks, %0d failed", test_num, name, test_checks, test_fails);
        total_checks += test_checks;
        total_fails  += test_fails;
        test_checks  = 0;
        test_fails   = 0;
    endtask

    initial begin : main
        int          i;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] r;
        lcg_state    = 32'd55;
        test_num     = 0;
        test_checks  = 0;
        test_fails   = 0;
        total_checks = 0;
        total_fails  = 0;
        rst_n        = 1'b0;
        req          = '{addr: '0, wd: '0, we: 1'b0, dt: mem_pkg::MEM_DT_WORD};
        repeat (4) @(posedge clk);  // 4 cycles in reset
        #2;
        rst_n = 1'b1;

        // every word written once with a pattern from the full byte address
        for (i = 0; i < `MEM_WORDS; i++) begin
            a = i * 4;
            do_req(a, {a[15:0] ^ 16'hc3a5, a[15:0]}, 1'b1, 3'd2);
        end
        end_test("preload");

        for (i = 0; i < 5; i++) begin
            a = (i * 32'h0000_0124) & 32'hffff_fffc;  // last ones wrap the index
            d = lcg_next();
            do_req(a, d, 1'b1, 3'd2);
            do_req(a, 32'h0, 1'b0, 3'd2);
        end
        end_test("word store and load");

        a = 32'h10;
        do_req(a, 32'h1122_3344, 1'b1, 3'd2);
        for (i = 0; i < 4; i++) begin
            do_req(a + i, 32'hffff_ff80 | i, 1'b1, 3'd0);  // bit 7 set with junk above
            do_req(a, 32'h0, 1'b0, 3'd2);                  // only that lane moved
        end
        for (i = 0; i < 4; i++) begin
            do_req(a + i, 32'h0, 1'b0, 3'd0);
            do_req(a + i, 32'h0, 1'b0, 3'd3);
        end
        end_test("byte lanes");

        a = 32'h20;
        do_req(a, 32'h0, 1'b1, 3'd2);
        do_req(a, 32'h5555_8001, 1'b1, 3'd1);      // negative low half
        do_req(a + 2, 32'habcd_7ffe, 1'b1, 3'd4);  // positive high half
        do_req(a, 32'h0, 1'b0, 3'd2);
        do_req(a, 32'h0, 1'b0, 3'd1);
        do_req(a, 32'h0, 1'b0, 3'd4);
        do_req(a + 2, 32'h0, 1'b0, 3'd1);
        do_req(a + 2, 32'h0, 1'b0, 3'd4);
        end_test("halfwords");

        a = 32'h30;
        do_req(a, 32'hcafe_f00d, 1'b1, 3'd2);
        do_req(a + 1, 32'h1111_1111, 1'b1, 3'd1);
        do_req(a + 3, 32'h2222_2222, 1'b1, 3'd4);
        for (i = 1; i < 4; i++) begin
            do_req(a + i, 32'h3333_3333, 1'b1, 3'd2);
        end
        for (i = 5; i < 8; i++) begin
            do_req(a, 32'h4444_4444, 1'b1, i[2:0]);  // bad types read zero
        end
        do_req(a + 1, 32'h0, 1'b0, 3'd1);
        do_req(a, 32'h0, 1'b0, 3'd2);  // word still intact
        end_test("errors");

        a = 32'h40;
        for (i = 0; i < 4; i++) begin
            do_req(a + 4 * i, 32'h0f0f_0000 | i, 1'b1, 3'd2);
        end
        set_reset(1'b0);
        for (i = 0; i < 4; i++) begin
            // each store held two cycles so rd must not move
            repeat (2) do_req(a + 4 * i, 32'hdead_beef, 1'b1, 3'd2);
            repeat (2) do_req(a + 4 * i + 1, 32'h0000_00aa, 1'b1, 3'd3);
        end
        set_reset(1'b1);
        for (i = 0; i < 4; i++) begin
            do_req(a + 4 * i, 32'h0, 1'b0, 3'd2);
        end
        end_test("stores in reset");

        for (i = 0; i < 200; i++) begin
            a = lcg_next();
            d = lcg_next();
            r = lcg_next();
            do_req(a, d, r[28], r[31:29]);  // all eight type codes
        end
        end_test("random");

        $display("checks %0d, failed %0d, assertion failures %0d", total_checks, total_fails,
                 i_data_mem.i_data_mem_checker.fail_count);
        if (total_fails == 0 && i_data_mem.i_data_mem_checker.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+verilog
verilog/mem_pkg.sv
verilog/mem_access.sv
verilog/mem_be.sv
verilog/data_mem.sv
test/data_mem_checker.sv
test/data_mem_tb.sv
